// File: hdl/ex_params.svh
//////////////////////////////
// Execute stage parameters
// Widths and step counts shared by the RTL and the testbench
//////////////////////////////

`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// Data word width
`define EX_XLEN 32

// Register file address width
`define EX_RADDR_W 5

// Multiplier iterations, one per multiplier bit
`define EX_MUL_STEPS 32

// Shift amount taken from operand b
`define EX_SHAMT_W 5

`endif

// File: hdl/ex_pkg.sv
//////////////////////////////
// Execute stage package
// Word, address and operation types
//////////////////////////////

`include "ex_params.svh"

`default_nettype none

package ex_pkg;

  // One data word
  typedef logic [`EX_XLEN-1:0] word_t;

  // Destination register index
  typedef logic [`EX_RADDR_W-1:0] reg_addr_t;

  // ALU operations
  typedef enum logic [4:0] {
    ALU_ADD  = 5'd0,
    ALU_SUB  = 5'd1,
    ALU_AND  = 5'd2,
    ALU_OR   = 5'd3,
    ALU_XOR  = 5'd4,
    ALU_SLL  = 5'd5,
    ALU_SRL  = 5'd6,
    ALU_SRA  = 5'd7,
    ALU_SLT  = 5'd8,
    ALU_SLTU = 5'd9,
    // Branch compares, flag only
    ALU_EQ   = 5'd10,
    ALU_NE   = 5'd11,
    ALU_LT   = 5'd12,
    ALU_GE   = 5'd13,
    ALU_LTU  = 5'd14,
    ALU_GEU  = 5'd15
  } alu_op_e;

  // Multiply operations
  typedef enum logic [1:0] {
    MUL_L   = 2'd0,
    MUL_H   = 2'd1,
    MUL_HU  = 2'd2,
    MUL_HSU = 2'd3
  } mul_op_e;

endpackage

`default_nettype wire

// File: hdl/ex_alu.sv
//////////////////////////////
// Execute stage ALU
// Single-cycle add, logic, shift, set-less-than and branch compares
//////////////////////////////

`include "ex_params.svh"

`default_nettype none

module ex_alu (
  input  ex_pkg::alu_op_e op_i,
  input  ex_pkg::word_t   operand_a_i,
  input  ex_pkg::word_t   operand_b_i,
  output ex_pkg::word_t   result_o,
  output logic            cmp_result_o
);

  localparam int XLEN = `EX_XLEN;

  logic                   sub_en;
  ex_pkg::word_t          adder_b;
  logic [XLEN:0]          adder_full;
  ex_pkg::word_t          adder_result;
  logic                   is_equal;
  logic                   lt_u;
  logic                   lt_s;
  ex_pkg::word_t          sum_result;
  logic [`EX_SHAMT_W-1:0] shamt;
  logic                   shift_left;
  ex_pkg::word_t          shift_in;
  logic [XLEN:0]          shift_ext;
  ex_pkg::word_t          shift_right;
  ex_pkg::word_t          shift_result;

  //////////////////////////////
  // Adder
  //////////////////////////////

  // Everything but ADD subtracts: SUB, SLT(U) and the compares
  assign sub_en       = (op_i != ex_pkg::ALU_ADD);
  assign adder_b      = sub_en ? ~operand_b_i : operand_b_i;
  assign adder_full   = {1'b0, operand_a_i} + {1'b0, adder_b} + (XLEN+1)'(sub_en);
  assign adder_result = adder_full[XLEN-1:0];

  // Carry out of a - b is set when a >= b unsigned
  assign lt_u     = ~adder_full[XLEN];
  // Sign bits decide when they differ, else the unsigned order holds
  assign lt_s     = (operand_a_i[XLEN-1] != operand_b_i[XLEN-1]) ?
                    operand_a_i[XLEN-1] : lt_u;
  assign is_equal = (adder_result == '0);

  // Compares leave the plain sum on the result word
  assign sum_result = operand_a_i + operand_b_i;

  //////////////////////////////
  // Shifter
  //////////////////////////////

  // One right shifter, left shifts run bit-reversed through it
  assign shamt       = operand_b_i[`EX_SHAMT_W-1:0];
  assign shift_left  = (op_i == ex_pkg::ALU_SLL);
  assign shift_in    = shift_left ? {<<{operand_a_i}} : operand_a_i;
  // Extra top bit carries the fill, set only for SRA of a negative word
  assign shift_ext   = {(op_i == ex_pkg::ALU_SRA) && operand_a_i[XLEN-1], shift_in};
  assign shift_right = XLEN'($signed(shift_ext) >>> shamt);
  assign shift_result = shift_left ? {<<{shift_right}} : shift_right;

  // Result select
  always_comb begin
    case (op_i)
      ex_pkg::ALU_ADD,
      ex_pkg::ALU_SUB:  result_o = adder_result;
      ex_pkg::ALU_AND:  result_o = operand_a_i & operand_b_i;
      ex_pkg::ALU_OR:   result_o = operand_a_i | operand_b_i;
      ex_pkg::ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ex_pkg::ALU_SLL,
      ex_pkg::ALU_SRL,
      ex_pkg::ALU_SRA:  result_o = shift_result;
      ex_pkg::ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_s};
      ex_pkg::ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_u};
      default:          result_o = sum_result;
    endcase
  end

  // Branch compare flag
  always_comb begin
    case (op_i)
      ex_pkg::ALU_EQ:  cmp_result_o = is_equal;
      ex_pkg::ALU_NE:  cmp_result_o = ~is_equal;
      ex_pkg::ALU_LT:  cmp_result_o = lt_s;
      ex_pkg::ALU_GE:  cmp_result_o = ~lt_s;
      ex_pkg::ALU_LTU: cmp_result_o = lt_u;
      ex_pkg::ALU_GEU: cmp_result_o = ~lt_u;
      default:         cmp_result_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/ex_mult.sv
//////////////////////////////
// Iterative multiplier
// Shift-add MUL, MULH, MULHU and MULHSU with start/done handshake
//////////////////////////////

`include "ex_params.svh"

`default_nettype none

module ex_mult (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start_i,
  input  ex_pkg::mul_op_e op_i,
  input  ex_pkg::word_t   op_a_i,
  input  ex_pkg::word_t   op_b_i,
  input  logic            retire_i,
  output logic            done_o,
  output ex_pkg::word_t   result_o
);

  localparam int XLEN  = `EX_XLEN;
  localparam int STEPS = `EX_MUL_STEPS;
  localparam int CNT_W = $clog2(STEPS);

  typedef enum logic [1:0] {
    MUL_IDLE,
    MUL_RUN,
    MUL_DONE
  } mul_state_e;

  mul_state_e        state_q;
  mul_state_e        state_d;
  logic [CNT_W-1:0]  step_q;
  logic              last_step;
  logic              a_signed;
  logic              b_signed;
  logic              b_signed_q;
  logic              high_q;
  logic [2*XLEN-1:0] mcand_q;
  logic [2*XLEN-1:0] acc_q;
  logic [2*XLEN-1:0] acc_next;
  ex_pkg::word_t     mplier_q;

  // Operand a is signed except for MULHU, b only for MULH
  assign a_signed = (op_i != ex_pkg::MUL_HU);
  assign b_signed = (op_i == ex_pkg::MUL_H);

  assign last_step = (step_q == CNT_W'(STEPS - 1));

  //////////////////////////////
  // Control
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      MUL_IDLE: begin
        if (start_i) begin
          state_d = MUL_RUN;
        end
      end
      MUL_RUN: begin
        // Dropped start means kill or halt, abandon the product
        if (!start_i) begin
          state_d = MUL_IDLE;
        end else if (last_step) begin
          state_d = MUL_DONE;
        end
      end
      MUL_DONE: begin
        // Result held until WB takes it
        if (!start_i || retire_i) begin
          state_d = MUL_IDLE;
        end
      end
      default: state_d = MUL_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MUL_IDLE;
      step_q  <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == MUL_RUN) begin
        step_q <= step_q + 1'b1;
      end else begin
        step_q <= '0;
      end
    end
  end

  //////////////////////////////
  // Datapath
  //////////////////////////////

  // Sign bit of a signed multiplier has weight -2^31, so the last step subtracts
  always_comb begin
    acc_next = acc_q;
    if (mplier_q[0]) begin
      acc_next = (last_step && b_signed_q) ? acc_q - mcand_q : acc_q + mcand_q;
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == MUL_IDLE) && start_i) begin
      // Multiplicand extended to 64 bits per operation
      mcand_q    <= a_signed ? {{XLEN{op_a_i[XLEN-1]}}, op_a_i} : {{XLEN{1'b0}}, op_a_i};
      mplier_q   <= op_b_i;
      acc_q      <= '0;
      b_signed_q <= b_signed;
      high_q     <= (op_i != ex_pkg::MUL_L);
    end else if (state_q == MUL_RUN) begin
      acc_q    <= acc_next;
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  assign done_o   = (state_q == MUL_DONE);
  assign result_o = high_q ? acc_q[2*XLEN-1:XLEN] : acc_q[XLEN-1:0];

endmodule

`default_nettype wire

// File: hdl/ex_issue_ctrl.sv
//////////////////////////////
// Execute stage issue control
// Kill/halt gating, unit handshakes, result select and branch decision
//////////////////////////////

`default_nettype none

module ex_issue_ctrl (
  input  logic          id_valid_i,
  input  logic          id_alu_en_i,
  input  logic          id_mul_en_i,
  input  logic          id_branch_i,
  input  ex_pkg::word_t id_branch_target_i,
  input  logic          kill_ex_i,
  input  logic          halt_ex_i,
  input  logic          wb_ready_i,
  input  ex_pkg::word_t alu_result_i,
  input  logic          alu_cmp_i,
  input  logic          mul_done_i,
  input  ex_pkg::word_t mul_result_i,
  output logic          mul_start_o,
  output logic          mul_retire_o,
  output logic          ex_valid_o,
  output logic          ex_ready_o,
  output ex_pkg::word_t result_o,
  output logic          branch_decision_o,
  output ex_pkg::word_t branch_target_o,
  output logic          branch_taken_o
);

  logic instr_valid;
  logic alu_ready;
  logic mul_valid;
  logic mul_ready;

  // Instruction in EX that is neither killed nor halted
  assign instr_valid = id_valid_i && !kill_ex_i && !halt_ex_i;

  //////////////////////////////
  // Unit handshakes
  //////////////////////////////

  // ALU finishes in the cycle it is presented
  assign alu_ready = wb_ready_i;

  // Multiplier runs while the gated multiply sits in EX
  assign mul_start_o  = id_mul_en_i && instr_valid;
  assign mul_valid    = mul_done_i;
  assign mul_ready    = !mul_start_o || mul_done_i;
  // Retire on the edge the result moves into EX/WB
  assign mul_retire_o = mul_start_o && wb_ready_i;

  // Kill always frees the stage and halt blocks it otherwise
  assign ex_ready_o = kill_ex_i || (alu_ready && mul_ready && !halt_ex_i);

  assign ex_valid_o = (id_alu_en_i || (id_mul_en_i && mul_valid)) && instr_valid;

  // Write-back data
  assign result_o = id_mul_en_i ? mul_result_i : alu_result_i;

  //////////////////////////////
  // Branch
  //////////////////////////////

  // Decision to IF in the same cycle as the branch is presented
  assign branch_decision_o = instr_valid && id_branch_i && alu_cmp_i;
  assign branch_target_o   = id_branch_target_i;
  // Taken flag carried on to WB
  assign branch_taken_o    = id_branch_i && alu_cmp_i;

endmodule

`default_nettype wire

// File: hdl/ex_wb_reg.sv
//////////////////////////////
// EX/WB pipeline register
// Loads on ex_valid with wb_ready, bubbles otherwise
//////////////////////////////

`default_nettype none

module ex_wb_reg (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              ex_valid_i,
  input  logic              wb_ready_i,
  input  logic              rf_we_i,
  input  ex_pkg::reg_addr_t rf_waddr_i,
  input  ex_pkg::word_t     rf_wdata_i,
  input  logic              branch_taken_i,
  output logic              wb_valid_o,
  output logic              wb_rf_we_o,
  output ex_pkg::reg_addr_t wb_rf_waddr_o,
  output ex_pkg::word_t     wb_rf_wdata_o,
  output logic              wb_branch_taken_o
);

  logic load;
  logic bubble;

  // Handshake with WB
  assign load   = ex_valid_i && wb_ready_i;
  assign bubble = !ex_valid_i && wb_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_o        <= 1'b0;
      wb_rf_we_o        <= 1'b0;
      wb_rf_waddr_o     <= '0;
      wb_rf_wdata_o     <= '0;
      wb_branch_taken_o <= 1'b0;
    end else begin
      if (load) begin
        wb_valid_o        <= 1'b1;
        wb_rf_we_o        <= rf_we_i;
        wb_branch_taken_o <= branch_taken_i;
        // Address and data kept from the last writing instruction
        if (rf_we_i) begin
          wb_rf_waddr_o <= rf_waddr_i;
          wb_rf_wdata_o <= rf_wdata_i;
        end
      end else if (bubble) begin
        // WB took the old entry, nothing new behind it
        wb_valid_o        <= 1'b0;
        wb_rf_we_o        <= 1'b0;
        wb_branch_taken_o <= 1'b0;
      end
      // wb_ready_i low, everything holds
    end
  end

endmodule

`default_nettype wire

// File: hdl/ex_stage.sv
//////////////////////////////
// Execute stage top
// Issue control, ALU, multiplier and EX/WB register
//////////////////////////////

`default_nettype none

module ex_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              id_valid_i,
  input  logic              id_alu_en_i,
  input  logic              id_mul_en_i,
  input  ex_pkg::alu_op_e   id_alu_op_i,
  input  ex_pkg::mul_op_e   id_mul_op_i,
  input  ex_pkg::word_t     id_operand_a_i,
  input  ex_pkg::word_t     id_operand_b_i,
  input  logic              id_branch_i,
  input  ex_pkg::word_t     id_branch_target_i,
  input  logic              id_rf_we_i,
  input  ex_pkg::reg_addr_t id_rf_waddr_i,
  input  logic              kill_ex_i,
  input  logic              halt_ex_i,
  input  logic              wb_ready_i,
  output logic              ex_ready_o,
  output logic              branch_decision_o,
  output ex_pkg::word_t     branch_target_o,
  output logic              wb_valid_o,
  output logic              wb_rf_we_o,
  output ex_pkg::reg_addr_t wb_rf_waddr_o,
  output ex_pkg::word_t     wb_rf_wdata_o,
  output logic              wb_branch_taken_o
);

  // ALU
  ex_pkg::word_t alu_result;
  logic          alu_cmp;
  // Multiplier handshake
  logic          mul_start;
  logic          mul_retire;
  logic          mul_done;
  ex_pkg::word_t mul_result;
  // Towards EX/WB
  logic          ex_valid;
  ex_pkg::word_t ex_result;
  logic          branch_taken;

  ex_issue_ctrl i_ex_issue_ctrl (
    .id_valid_i        (id_valid_i),
    .id_alu_en_i       (id_alu_en_i),
    .id_mul_en_i       (id_mul_en_i),
    .id_branch_i       (id_branch_i),
    .id_branch_target_i(id_branch_target_i),
    .kill_ex_i         (kill_ex_i),
    .halt_ex_i         (halt_ex_i),
    .wb_ready_i        (wb_ready_i),
    .alu_result_i      (alu_result),
    .alu_cmp_i         (alu_cmp),
    .mul_done_i        (mul_done),
    .mul_result_i      (mul_result),
    .mul_start_o       (mul_start),
    .mul_retire_o      (mul_retire),
    .ex_valid_o        (ex_valid),
    .ex_ready_o        (ex_ready_o),
    .result_o          (ex_result),
    .branch_decision_o (branch_decision_o),
    .branch_target_o   (branch_target_o),
    .branch_taken_o    (branch_taken)
  );

  ex_alu i_ex_alu (
    .op_i        (id_alu_op_i),
    .operand_a_i (id_operand_a_i),
    .operand_b_i (id_operand_b_i),
    .result_o    (alu_result),
    .cmp_result_o(alu_cmp)
  );

  ex_mult i_ex_mult (
    .clk     (clk),
    .rst_n   (rst_n),
    .start_i (mul_start),
    .op_i    (id_mul_op_i),
    .op_a_i  (id_operand_a_i),
    .op_b_i  (id_operand_b_i),
    .retire_i(mul_retire),
    .done_o  (mul_done),
    .result_o(mul_result)
  );

  ex_wb_reg i_ex_wb_reg (
    .clk              (clk),
    .rst_n            (rst_n),
    .ex_valid_i       (ex_valid),
    .wb_ready_i       (wb_ready_i),
    .rf_we_i          (id_rf_we_i),
    .rf_waddr_i       (id_rf_waddr_i),
    .rf_wdata_i       (ex_result),
    .branch_taken_i   (branch_taken),
    .wb_valid_o       (wb_valid_o),
    .wb_rf_we_o       (wb_rf_we_o),
    .wb_rf_waddr_o    (wb_rf_waddr_o),
    .wb_rf_wdata_o    (wb_rf_wdata_o),
    .wb_branch_taken_o(wb_branch_taken_o)
  );

endmodule

`default_nettype wire

// File: bench/ex_stage_chk.sv
//////////////////////////////
// Execute stage checker
// Concurrent assertions on the top-level ports
//////////////////////////////

`default_nettype none

module ex_stage_chk (
  input logic              clk,
  input logic              rst_n,
  input logic              kill_ex_i,
  input logic              wb_ready_i,
  input logic              ex_ready_o,
  input logic              wb_valid_o,
  input logic              wb_rf_we_o,
  input ex_pkg::reg_addr_t wb_rf_waddr_o,
  input ex_pkg::word_t     wb_rf_wdata_o,
  input logic              wb_branch_taken_o
);

  // Failures seen so far, read by the testbench at the end
  int fail_cnt = 0;

  // A register write needs a valid entry behind it
  rf_we_needs_valid: assert property (
    @(posedge clk) disable iff (!rst_n) wb_rf_we_o |-> wb_valid_o
  ) else begin
    $error("wb_rf_we_o high without wb_valid_o");
    fail_cnt++;
  end

  // WB stalled on a valid entry, nothing may move
  wb_hold_on_stall: assert property (
    @(posedge clk) disable iff (!rst_n)
    wb_valid_o && !wb_ready_i |=> $stable(wb_valid_o) && $stable(wb_rf_we_o) &&
      $stable(wb_rf_waddr_o) && $stable(wb_rf_wdata_o) && $stable(wb_branch_taken_o)
  ) else begin
    $error("wb outputs changed while WB was stalled");
    fail_cnt++;
  end

  // Kill always frees the stage
  kill_frees_stage: assert property (
    @(posedge clk) disable iff (!rst_n) kill_ex_i |-> ex_ready_o
  ) else begin
    $error("ex_ready_o low while kill_ex_i is high");
    fail_cnt++;
  end

endmodule

bind ex_stage ex_stage_chk i_ex_stage_chk (
  .clk              (clk),
  .rst_n            (rst_n),
  .kill_ex_i        (kill_ex_i),
  .wb_ready_i       (wb_ready_i),
  .ex_ready_o       (ex_ready_o),
  .wb_valid_o       (wb_valid_o),
  .wb_rf_we_o       (wb_rf_we_o),
  .wb_rf_waddr_o    (wb_rf_waddr_o),
  .wb_rf_wdata_o    (wb_rf_wdata_o),
  .wb_branch_taken_o(wb_branch_taken_o)
);

`default_nettype wire

// File: bench/ex_stage_tb.sv
//////////////////////////////
// Execute stage testbench
// Directed tests of ALU, branch, multiply, back-pressure, kill and halt
//////////////////////////////

`include "ex_params.svh"

`default_nettype none

module ex_stage_tb;

  localparam int XLEN       = `EX_XLEN;
  localparam int HALF_CYCLE = 20;
  // 40 instructions with a full multiply and margin each
  localparam int MAX_CYCLES = 40 * (`EX_MUL_STEPS + 8);

  logic              clk;
  logic              rst_n;
  logic              id_valid_i;
  logic              id_alu_en_i;
  logic              id_mul_en_i;
  ex_pkg::alu_op_e   id_alu_op_i;
  ex_pkg::mul_op_e   id_mul_op_i;
  ex_pkg::word_t     id_operand_a_i;
  ex_pkg::word_t     id_operand_b_i;
  logic              id_branch_i;
  ex_pkg::word_t     id_branch_target_i;
  logic              id_rf_we_i;
  ex_pkg::reg_addr_t id_rf_waddr_i;
  logic              kill_ex_i;
  logic              halt_ex_i;
  logic              wb_ready_i;
  logic              ex_ready_o;
  logic              branch_decision_o;
  ex_pkg::word_t     branch_target_o;
  logic              wb_valid_o;
  logic              wb_rf_we_o;
  ex_pkg::reg_addr_t wb_rf_waddr_o;
  ex_pkg::word_t     wb_rf_wdata_o;
  logic              wb_branch_taken_o;

  integer            seed;
  int                err_cnt;
  int                errs_at_start;
  int                test_cnt;
  int                cycle_cnt;
  int                deliver_cnt;
  int                wait_cycles;
  // Expected WB address and data of the last writing instruction
  ex_pkg::reg_addr_t last_waddr;
  ex_pkg::word_t     last_wdata;

  ex_stage i_ex_stage (.*);

  always #HALF_CYCLE clk = ~clk;

  // Timeout and count of results taken by WB
  always @(posedge clk) begin
    cycle_cnt++;
    if (rst_n && wb_valid_o && wb_ready_i) begin
      deliver_cnt++;
    end
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("tests failed");
      $finish;
    end
  end

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_word(input string name, input ex_pkg::word_t exp,
                            input ex_pkg::word_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_addr(input string name, input ex_pkg::reg_addr_t exp,
                            input ex_pkg::reg_addr_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      err_cnt++;
    end
  endtask

  //////////////////////////////
  // Reference and drivers
  //////////////////////////////

  // Expected result word and compare flag from the RV32I/M rules
  task automatic ref_model(input logic is_mul, input ex_pkg::alu_op_e aop,
                           input ex_pkg::mul_op_e mop, input ex_pkg::word_t a,
                           input ex_pkg::word_t b, output ex_pkg::word_t res,
                           output logic cmp);
    logic [2*XLEN-1:0] wide_a;
    logic [2*XLEN-1:0] wide_b;
    logic [2*XLEN-1:0] prod;
    wide_a = {{XLEN{a[XLEN-1] && (mop != ex_pkg::MUL_HU)}}, a};
    wide_b = {{XLEN{b[XLEN-1] && (mop == ex_pkg::MUL_H)}}, b};
    prod   = wide_a * wide_b;
    res    = a + b;
    cmp    = 1'b0;
    if (is_mul) begin
      res = (mop == ex_pkg::MUL_L) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];
    end else begin
      case (aop)
        ex_pkg::ALU_SUB:  res = a - b;
        ex_pkg::ALU_AND:  res = a & b;
        ex_pkg::ALU_OR:   res = a | b;
        ex_pkg::ALU_XOR:  res = a ^ b;
        ex_pkg::ALU_SLL:  res = a << b[`EX_SHAMT_W-1:0];
        ex_pkg::ALU_SRL:  res = a >> b[`EX_SHAMT_W-1:0];
        ex_pkg::ALU_SRA:  res = $signed(a) >>> b[`EX_SHAMT_W-1:0];
        ex_pkg::ALU_SLT:  res = ($signed(a) < $signed(b)) ? 1 : 0;
        ex_pkg::ALU_SLTU: res = (a < b) ? 1 : 0;
        ex_pkg::ALU_EQ:   cmp = (a == b);
        ex_pkg::ALU_NE:   cmp = (a != b);
        ex_pkg::ALU_LT:   cmp = ($signed(a) < $signed(b));
        ex_pkg::ALU_GE:   cmp = ($signed(a) >= $signed(b));
        ex_pkg::ALU_LTU:  cmp = (a < b);
        ex_pkg::ALU_GEU:  cmp = (a >= b);
        default:          res = a + b;
      endcase
    end
  endtask

  function automatic ex_pkg::word_t rand_word();
    return ex_pkg::word_t'($random(seed));
  endfunction

  // One rising edge, then the usual drive offset
  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  // Presents one instruction from ID
  task automatic drive_instr(input logic is_mul, input ex_pkg::alu_op_e aop,
                             input ex_pkg::mul_op_e mop, input ex_pkg::word_t a,
                             input ex_pkg::word_t b, input logic br, input logic we);
    id_valid_i         = 1'b1;
    id_alu_en_i        = !is_mul;
    id_mul_en_i        = is_mul;
    id_alu_op_i        = aop;
    id_mul_op_i        = mop;
    id_operand_a_i     = a;
    id_operand_b_i     = b;
    id_branch_i        = br;
    id_branch_target_i = rand_word();
    id_rf_we_i         = we;
    id_rf_waddr_i      = ex_pkg::reg_addr_t'($random(seed));
  endtask

  // Waits for acceptance, then checks branch outputs and the WB entry
  task automatic finish_instr(input string name);
    ex_pkg::word_t     exp_res;
    logic              exp_cmp;
    logic              exp_taken;
    logic              exp_we;
    ex_pkg::reg_addr_t exp_addr;
    ref_model(id_mul_en_i, id_alu_op_i, id_mul_op_i, id_operand_a_i, id_operand_b_i,
              exp_res, exp_cmp);
    exp_taken   = id_branch_i && exp_cmp;
    exp_we      = id_rf_we_i;
    exp_addr    = id_rf_waddr_i;
    wait_cycles = 0;
    @(negedge clk);
    while (!ex_ready_o) begin
      wait_cycles++;
      @(negedge clk);
    end
    check_bit({name, " decision"}, exp_taken, branch_decision_o);
    check_word({name, " target"}, id_branch_target_i, branch_target_o);
    next_cycle();
    id_valid_i = 1'b0;
    if (exp_we) begin
      last_waddr = exp_addr;
      last_wdata = exp_res;
    end
    check_bit({name, " valid"}, 1'b1, wb_valid_o);
    check_bit({name, " rf_we"}, exp_we, wb_rf_we_o);
    check_bit({name, " taken"}, exp_taken, wb_branch_taken_o);
    check_addr({name, " waddr"}, last_waddr, wb_rf_waddr_o);
    check_word({name, " wdata"}, last_wdata, wb_rf_wdata_o);
  endtask

  // WB entry still the last written one
  task automatic check_held(input string name);
    check_bit({name, " valid"}, 1'b1, wb_valid_o);
    check_addr({name, " waddr"}, last_waddr, wb_rf_waddr_o);
    check_word({name, " wdata"}, last_wdata, wb_rf_wdata_o);
  endtask

  task automatic report(input string name);
    test_cnt++;
    $display("test %s finished, %0d errors", name, err_cnt - errs_at_start);
    errs_at_start = err_cnt;
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_reset();
    check_bit("reset wb_valid", 1'b0, wb_valid_o);
    check_bit("reset rf_we", 1'b0, wb_rf_we_o);
    check_bit("reset taken", 1'b0, wb_branch_taken_o);
    @(negedge clk);
    check_bit("reset ready", wb_ready_i, ex_ready_o);
    next_cycle();
  endtask

  // Random pair, then sign and shift-amount corners
  task automatic test_alu_ops();
    ex_pkg::alu_op_e op;
    ex_pkg::word_t   a;
    ex_pkg::word_t   b;
    for (int i = 0; i < 10; i++) begin
      op = ex_pkg::alu_op_e'(i);
      for (int j = 0; j < 3; j++) begin
        a = rand_word();
        b = rand_word();
        if (j == 1) begin
          a = 32'h8000_0000;
          b = 32'hffff_ffff;
        end else if (j == 2) begin
          a = 32'h7fff_ffff;
          b = 32'h8000_0001;
        end
        drive_instr(1'b0, op, ex_pkg::MUL_L, a, b, 1'b0, 1'b1);
        finish_instr($sformatf("%s set %0d", op.name(), j));
      end
    end
  endtask

  // Equal, less, greater, and signed/unsigned order split
  task automatic test_branches();
    ex_pkg::alu_op_e op;
    ex_pkg::word_t   a;
    ex_pkg::word_t   b;
    for (int i = 10; i < 16; i++) begin
      op = ex_pkg::alu_op_e'(i);
      for (int j = 0; j < 4; j++) begin
        a = rand_word();
        b = a;
        case (j)
          1: begin
            a = 32'h0000_0005;
            b = 32'h0000_0009;
          end
          2: begin
            a = 32'h0000_0009;
            b = 32'h0000_0005;
          end
          3: begin
            a = 32'hffff_fff0;
            b = 32'h0000_0003;
          end
          default: b = a;
        endcase
        // Written back so the sum on the result word is seen too
        drive_instr(1'b0, op, ex_pkg::MUL_L, a, b, 1'b1, 1'b1);
        finish_instr($sformatf("%s set %0d", op.name(), j));
      end
    end
  endtask

  task automatic test_multiply();
    ex_pkg::mul_op_e op;
    ex_pkg::word_t   a;
    ex_pkg::word_t   b;
    string           name;
    for (int i = 0; i < 4; i++) begin
      op = ex_pkg::mul_op_e'(i);
      for (int j = 0; j < 4; j++) begin
        a = rand_word();
        b = rand_word();
        if (j == 1) begin
          a = '0;
        end else if (j == 2) begin
          a = 32'h8000_0000;
          b = 32'h8000_0000;
        end else if (j == 3) begin
          a = '1;
          b = '1;
        end
        name = $sformatf("%s set %0d", op.name(), j);
        drive_instr(1'b1, ex_pkg::ALU_ADD, op, a, b, 1'b0, 1'b1);
        finish_instr(name);
        if (wait_cycles == 0) begin
          $display("%s: ex_ready_o was high while the multiply ran", name);
          err_cnt++;
        end
      end
    end
  endtask

  // WB stalls on an ALU result while a multiply completes behind it
  task automatic test_back_pressure();
    int delivered_before;
    next_cycle();
    delivered_before = deliver_cnt;
    drive_instr(1'b0, ex_pkg::ALU_XOR, ex_pkg::MUL_L, rand_word(), rand_word(), 1'b0, 1'b1);
    finish_instr("stall alu");
    wb_ready_i = 1'b0;
    repeat (5) begin
      @(negedge clk);
      check_held("stall alu hold");
    end
    next_cycle();
    drive_instr(1'b1, ex_pkg::ALU_ADD, ex_pkg::MUL_HSU, rand_word(), rand_word(), 1'b0, 1'b1);
    repeat (`EX_MUL_STEPS + 4) begin
      @(negedge clk);
      check_bit("stall mul ready", 1'b0, ex_ready_o);
      check_held("stall mul hold");
    end
    next_cycle();
    wb_ready_i = 1'b1;
    finish_instr("stall mul");
    next_cycle();
    check_bit("stall bubble", 1'b0, wb_valid_o);
    if (deliver_cnt - delivered_before != 2) begin
      $display("[ERROR] back_pressure deliveries: expected 2, actual %0d",
               deliver_cnt - delivered_before);
      err_cnt++;
    end
  endtask

  task automatic test_kill_halt();
    drive_instr(1'b1, ex_pkg::ALU_ADD, ex_pkg::MUL_H, rand_word(), rand_word(), 1'b0, 1'b1);
    repeat (10) begin
      @(negedge clk);
      check_bit("kill stall", 1'b0, ex_ready_o);
    end
    next_cycle();
    kill_ex_i = 1'b1;
    @(negedge clk);
    check_bit("kill ready", 1'b1, ex_ready_o);
    next_cycle();
    kill_ex_i  = 1'b0;
    id_valid_i = 1'b0;
    // Killed multiply must never reach WB
    repeat (`EX_MUL_STEPS + 4) begin
      check_bit("kill no result", 1'b0, wb_valid_o);
      next_cycle();
    end
    drive_instr(1'b0, ex_pkg::ALU_SUB, ex_pkg::MUL_L, rand_word(), rand_word(), 1'b0, 1'b1);
    finish_instr("after kill");
    next_cycle();
    halt_ex_i = 1'b1;
    drive_instr(1'b0, ex_pkg::ALU_SRA, ex_pkg::MUL_L, rand_word(), rand_word(), 1'b0, 1'b1);
    repeat (6) begin
      @(negedge clk);
      check_bit("halt ready", 1'b0, ex_ready_o);
      check_bit("halt no result", 1'b0, wb_valid_o);
    end
    next_cycle();
    halt_ex_i = 1'b0;
    finish_instr("halt release");
  endtask

  // Second instruction writes nothing and WB keeps the first address and data
  task automatic test_rf_we();
    drive_instr(1'b0, ex_pkg::ALU_OR, ex_pkg::MUL_L, rand_word(), rand_word(), 1'b0, 1'b1);
    finish_instr("rf_we on");
    drive_instr(1'b0, ex_pkg::ALU_AND, ex_pkg::MUL_L, rand_word(), rand_word(), 1'b0, 1'b0);
    finish_instr("rf_we off");
    drive_instr(1'b1, ex_pkg::ALU_ADD, ex_pkg::MUL_L, rand_word(), rand_word(), 1'b0, 1'b0);
    finish_instr("rf_we off mul");
  endtask

  initial begin
    seed               = 32'h8409_c999;
    clk                = 1'b0;
    rst_n              = 1'b0;
    id_valid_i         = 1'b0;
    id_alu_en_i        = 1'b1;
    id_mul_en_i        = 1'b0;
    id_alu_op_i        = ex_pkg::ALU_ADD;
    id_mul_op_i        = ex_pkg::MUL_L;
    id_operand_a_i     = '0;
    id_operand_b_i     = '0;
    id_branch_i        = 1'b0;
    id_branch_target_i = '0;
    id_rf_we_i         = 1'b0;
    id_rf_waddr_i      = '0;
    kill_ex_i          = 1'b0;
    halt_ex_i          = 1'b0;
    wb_ready_i         = 1'b1;
    err_cnt            = 0;
    errs_at_start      = 0;
    test_cnt           = 0;
    cycle_cnt          = 0;
    deliver_cnt        = 0;
    last_waddr         = '0;
    last_wdata         = '0;
    repeat (10) @(posedge clk);
    #5;
    rst_n = 1'b1;
    test_reset();
    report("reset");
    test_alu_ops();
    report("alu_ops");
    test_branches();
    report("branches");
    test_multiply();
    report("multiply");
    test_back_pressure();
    report("back_pressure");
    test_kill_halt();
    report("kill_halt");
    test_rf_we();
    report("rf_we");
    next_cycle();
    // Add assertion failures from the bound checker
    err_cnt += i_ex_stage.i_ex_stage_chk.fail_cnt;
    $display("%0d tests run, %0d errors", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: ex_stage.f
+incdir+hdl
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_mult.sv
hdl/ex_issue_ctrl.sv
hdl/ex_wb_reg.sv
hdl/ex_stage.sv
bench/ex_stage_chk.sv
bench/ex_stage_tb.sv
